// File: filelist.f
verilog/core_pkg.sv
verilog/register_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/riscv_core.sv
verif/core_checker.sv
verif/tb_riscv_core.sv

// File: verif/core_checker.sv
`timescale 1ns/1ps

module core_checker
  import core_pkg::*;
(
  input  logic  CLK,
  input  logic  rst,
  input  word_t i_mem_addr,
  input  logic  i_mem_en,
  input  logic  d_mem_en,
  input  logic  d_mem_we,
  input  word_t d_mem_addr,
  input  word_t d_mem_wdata,
  input  logic  end_of_run,      // pipeline drained so closing checks run
  output int    mismatch_count,
  output int    fault_count,
  output logic  checked          // closing checks done
);

  localparam int    n_acc     = 12;             // data memory accesses in program order
  localparam word_t hold_pc_a = 32'h0000_0064;  // add right after lw x20
  localparam word_t hold_pc_b = 32'h0000_0070;  // sw right after lw x22

  typedef struct packed {
    logic  is_store;
    word_t addr;
    word_t data;  // ignored for loads
  } access_t;

  access_t exp_acc [0:n_acc-1];
  int      n_mismatch = 0;
  int      n_fault    = 0;
  int      acc_idx    = 0;
  logic    done_flag  = 1'b0;
  word_t   exp_pc     = '0;    // reference pc
  logic    held       = 1'b0;  // hold already taken at exp_pc

  assign mismatch_count = n_mismatch;
  assign fault_count    = n_fault;
  assign checked        = done_flag;

  // expected accesses worked out by hand from RV32I semantics
  initial
  begin
    exp_acc[0]  = {1'b1, 32'h0000_0000, 32'h0000_03f0};  // andi chain result
    exp_acc[1]  = {1'b1, 32'h0000_0024, 32'h0000_0011};  // base from addi x9
    exp_acc[2]  = {1'b1, 32'h0000_0004, 32'hfe00_001e};  // sra
    exp_acc[3]  = {1'b1, 32'h0000_0008, 32'h1e00_001e};  // srl
    exp_acc[4]  = {1'b1, 32'h0000_000c, 32'hff00_000f};  // srai
    exp_acc[5]  = {1'b1, 32'h0000_0010, 32'h0000_0001};  // slt of negative against 5
    exp_acc[6]  = {1'b1, 32'h0000_0014, 32'h0000_0000};  // sltu
    exp_acc[7]  = {1'b0, 32'h0000_0080, 32'h0000_0000};  // lw x20
    exp_acc[8]  = {1'b1, 32'h0000_0018, 32'h0000_1239};  // load-use add
    exp_acc[9]  = {1'b0, 32'h0000_0084, 32'h0000_0000};  // lw x22
    exp_acc[10] = {1'b1, 32'h0000_001c, 32'hfedc_ba98};  // load then sw
    exp_acc[11] = {1'b1, 32'h0000_0020, 32'h0000_0000};  // x0 stays zero
  end

  task automatic report_mismatch(input string msg);
    $display("mismatch at %0t ns: %s", $time, msg);
    n_mismatch++;
  endtask

  task automatic report_fault(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    n_fault++;
  endtask

  // reference pc steps by 4 and stays for one cycle on each load-use consumer
  task automatic check_fetch();
    logic exp_en;
    exp_en = !((exp_pc == hold_pc_a || exp_pc == hold_pc_b) && !held);
    if (i_mem_addr !== exp_pc)
      report_mismatch($sformatf("fetch addr %h, expected %h", i_mem_addr, exp_pc));
    if (i_mem_en !== exp_en)
      report_mismatch($sformatf("fetch en %b at %h, expected %b", i_mem_en, exp_pc,
                                exp_en));
    held = !exp_en;
    if (exp_en)
      exp_pc = exp_pc + 32'd4;
  endtask

  task automatic check_access();
    access_t e;
    if (acc_idx >= n_acc)
      report_fault($sformatf("extra data memory access at address %h", d_mem_addr));
    else
    begin
      e = exp_acc[acc_idx];
      if (d_mem_we !== e.is_store)
        report_mismatch($sformatf("access %0d we %b, expected %b", acc_idx, d_mem_we,
                                  e.is_store));
      else if (d_mem_addr !== e.addr)
        report_mismatch($sformatf("access %0d addr %h, expected %h", acc_idx, d_mem_addr,
                                  e.addr));
      else if (e.is_store && (d_mem_wdata !== e.data))
        report_mismatch($sformatf("store %0d data %h, expected %h", acc_idx, d_mem_wdata,
                                  e.data));
    end
    acc_idx++;
  endtask

  task automatic finish_checks();
    if (acc_idx < n_acc)
      report_fault($sformatf("missing stores, only %0d of %0d accesses seen", acc_idx, n_acc));
    done_flag = 1'b1;
  endtask

  // outputs sampled at the rising edge while inputs move on the falling one
  always @(posedge CLK)
  begin
    if (rst)
    begin
      if (i_mem_en !== 1'b0 || d_mem_en !== 1'b0 || d_mem_we !== 1'b0)
        report_fault("memory enable high during reset");
    end
    else
    begin
      check_fetch();
      if (d_mem_en === 1'b1)
        check_access();
      else if (d_mem_we !== 1'b0)
        report_fault("data write strobe without enable");
      if (end_of_run && !done_flag)
        finish_checks();
    end
  end

endmodule

// File: verif/tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core
  import core_pkg::*;
();

  localparam int prog_len = 31;
  localparam int end_addr = (prog_len + 6) * 4;          // last store long retired
  localparam int watchdog_ns = (prog_len + 20) * 100 * 2;

  logic  CLK = 1'b0;
  logic  rst;
  logic  end_of_run;
  word_t i_mem_addr, i_mem_rdata;
  logic  i_mem_en;
  logic  d_mem_en, d_mem_we;
  word_t d_mem_addr, d_mem_wdata, d_mem_rdata;
  int    mismatch_count, fault_count;
  logic  checked;

  word_t prog [0:prog_len-1];  // program table
  word_t imem [0:255];
  word_t dmem [0:63];

  always #50 CLK = ~CLK;  // 100 ns period

  // word read even while fetch is held since decode needs it for the hazard check
  assign i_mem_rdata = imem[i_mem_addr[9:2]];
  assign d_mem_rdata = dmem[d_mem_addr[7:2]];

  always @(posedge CLK)
  begin
    if (d_mem_we)
      dmem[d_mem_addr[7:2]] <= d_mem_wdata;
  end

  // small assembler helpers with rd / rs1 / rs2 in assembly order
  function automatic word_t encode_r(input logic [2:0] f3, input logic [6:0] f7,
                                     input reg_addr_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic word_t encode_i(input logic [6:0] opc, input logic [2:0] f3,
                                     input reg_addr_t rd, rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t encode_sw(input reg_addr_t rs2, rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opc_store};
  endfunction

  function automatic word_t encode_lui(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, opc_lui};
  endfunction

  task automatic build_program();
    prog[0]  = encode_i(opc_op_imm, 3'b000, 1, 0, 12'd5);     // addi x1 = 5
    prog[1]  = encode_i(opc_op_imm, 3'b000, 2, 1, 12'd7);     // x2 = 12 from x1 at distance 1
    prog[2]  = encode_r(3'b000, 7'h00, 3, 1, 2);              // add x3 = 17
    prog[3]  = encode_r(3'b000, 7'h20, 4, 3, 1);              // sub x4 = 12 with x1 at distance 3
    prog[4]  = encode_i(opc_op_imm, 3'b100, 5, 2, 12'h0ff);   // xori x5 = f3
    prog[5]  = encode_r(3'b110, 7'h00, 6, 4, 5);              // or x6 = ff
    prog[6]  = encode_i(opc_op_imm, 3'b001, 7, 6, 12'h004);   // slli x7 = ff0
    prog[7]  = encode_i(opc_op_imm, 3'b111, 8, 7, 12'h3f0);   // andi x8 = 3f0
    prog[8]  = encode_sw(8, 0, 12'h000);
    prog[9]  = encode_i(opc_op_imm, 3'b000, 9, 0, 12'h020);   // x9 = 20
    prog[10] = encode_sw(3, 9, 12'h004);                      // forwarded base
    prog[11] = encode_lui(10, 20'hf0000);
    prog[12] = encode_i(opc_op_imm, 3'b110, 10, 10, 12'h0f0); // ori x10 = f00000f0
    prog[13] = encode_i(opc_op_imm, 3'b000, 13, 0, 12'd3);
    prog[14] = encode_r(3'b101, 7'h20, 14, 10, 13);           // sra
    prog[15] = encode_r(3'b101, 7'h00, 15, 10, 13);           // srl
    prog[16] = encode_i(opc_op_imm, 3'b101, 16, 10, 12'h404); // srai 4
    prog[17] = encode_sw(14, 0, 12'h004);
    prog[18] = encode_sw(15, 0, 12'h008);
    prog[19] = encode_sw(16, 0, 12'h00c);
    prog[20] = encode_r(3'b010, 7'h00, 17, 10, 1);            // slt
    prog[21] = encode_r(3'b011, 7'h00, 18, 10, 1);            // sltu
    prog[22] = encode_sw(17, 0, 12'h010);
    prog[23] = encode_sw(18, 0, 12'h014);
    prog[24] = encode_i(opc_load, 3'b010, 20, 0, 12'h080);    // lw x20
    prog[25] = encode_r(3'b000, 7'h00, 21, 20, 1);            // load-use stall
    prog[26] = encode_sw(21, 0, 12'h018);
    prog[27] = encode_i(opc_load, 3'b010, 22, 0, 12'h084);    // lw x22
    prog[28] = encode_sw(22, 0, 12'h01c);                     // stalls on rs2
    prog[29] = encode_i(opc_op_imm, 3'b000, 0, 0, 12'd5);     // write to x0 dropped
    prog[30] = encode_sw(0, 0, 12'h020);
  endtask

  riscv_core DUT (
    .CLK         (CLK),
    .rst         (rst),
    .i_mem_addr  (i_mem_addr),
    .i_mem_en    (i_mem_en),
    .i_mem_rdata (i_mem_rdata),
    .d_mem_en    (d_mem_en),
    .d_mem_we    (d_mem_we),
    .d_mem_addr  (d_mem_addr),
    .d_mem_wdata (d_mem_wdata),
    .d_mem_rdata (d_mem_rdata)
  );

  core_checker u_check (
    .CLK            (CLK),
    .rst            (rst),
    .i_mem_addr     (i_mem_addr),
    .i_mem_en       (i_mem_en),
    .d_mem_en       (d_mem_en),
    .d_mem_we       (d_mem_we),
    .d_mem_addr     (d_mem_addr),
    .d_mem_wdata    (d_mem_wdata),
    .end_of_run     (end_of_run),
    .mismatch_count (mismatch_count),
    .fault_count    (fault_count),
    .checked        (checked)
  );

  initial
  begin
    rst        = 1'b1;
    end_of_run = 1'b0;
    build_program();
    for (int i = 0; i < 256; i++)
      imem[i] = (i < prog_len) ? prog[i] : nop_instr;  // nops past the end
    for (int i = 0; i < 64; i++)
      dmem[i] = 32'h5a5a_0000 | (i << 2);  // address-tagged fill
    dmem[32] = 32'h0000_1234;  // 0x80
    dmem[33] = 32'hfedc_ba98;  // 0x84
    repeat (10) @(negedge CLK);
    rst = 1'b0;
    while (i_mem_addr < end_addr)
      @(negedge CLK);
    end_of_run = 1'b1;
    wait (checked);
    $display("checks done: %0d mismatches, %0d other errors", mismatch_count, fault_count);
    if (mismatch_count == 0 && fault_count == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // watchdog
  initial
  begin
    #(watchdog_ns);
    $display("error: run timed out after %0d ns without draining", watchdog_ns);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: verilog/core_pkg.sv
package core_pkg;

  // datapath widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes handled by the decoder
  localparam logic [6:0] opc_op     = 7'b0110011;  // reg-reg alu
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // reg-imm alu
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  // funct3 codes
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_word    = 3'b010;  // lw / sw width

  // funct7 codes
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;  // sub, sra

  // addi x0,x0,0
  localparam word_t nop_instr = 32'h0000_0013;

  typedef enum logic [3:0] {
    alu_add    = 4'd0,  // must stay zero as a bubble decodes to it
    alu_sub    = 4'd1,
    alu_and    = 4'd2,
    alu_or     = 4'd3,
    alu_xor    = 4'd4,
    alu_sll    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_slt    = 4'd8,
    alu_sltu   = 4'd9,
    alu_pass_b = 4'd10  // lui
  } alu_op_t;

  typedef struct packed {
    alu_op_t alu_op;
    logic    use_imm;   // operand b from the immediate
    logic    zero_a;    // operand a forced to zero
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
  } ctrl_t;

  typedef struct packed {
    ctrl_t     ctrl;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;
  } id_ex_t;

  typedef struct packed {
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    reg_addr_t rd;
    word_t     alu_result;  // also the data address
    word_t     store_data;
  } ex_mem_t;

  typedef struct packed {
    logic      reg_write;
    reg_addr_t rd;
    word_t     data;
  } wb_t;

endpackage

// File: verilog/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
  import core_pkg::*;
(
  input  logic   CLK,
  input  logic   rst,
  input  word_t  instr,     // straight from instruction memory
  input  wb_t    wr,        // register write from writeback
  output word_t  pc,
  output logic   fetch_en,
  output id_ex_t id_ex
);

  logic [6:0] raw_opc;
  reg_addr_t  raw_rs1, raw_rs2;
  logic       reads_rs1, reads_rs2;
  logic       load_pending;
  logic       stall;
  word_t      dec_instr;   // instruction actually decoded
  logic [6:0] opc, f7;
  logic [2:0] f3;
  reg_addr_t  rd, rs1, rs2;
  logic       imm_shift_ok;
  ctrl_t      ctrl;
  word_t      imm;
  word_t      rs1_data, rs2_data;

  // load-use hazard seen on the raw fetched word
  assign raw_opc   = instr[6:0];
  assign raw_rs1   = instr[19:15];
  assign raw_rs2   = instr[24:20];
  assign reads_rs1 = raw_opc inside {opc_op, opc_op_imm, opc_load, opc_store};
  assign reads_rs2 = raw_opc inside {opc_op, opc_store};  // store data is rs2

  assign load_pending = id_ex.ctrl.mem_read && (id_ex.rd != '0);
  assign stall = load_pending && ((reads_rs1 && (raw_rs1 == id_ex.rd)) ||
                                  (reads_rs2 && (raw_rs2 == id_ex.rd)));

  assign fetch_en  = !rst && !stall;          // no fetch in reset or while held
  assign dec_instr = stall ? nop_instr : instr;  // nop issues as a bubble

  // pc holds on a stall so the consumer is fetched again
  always_ff @(posedge CLK)
  begin
    if (rst)
      pc <= '0;
    else if (!stall)
      pc <= pc + 32'd4;
  end

  // instruction fields
  assign opc = dec_instr[6:0];
  assign rd  = dec_instr[11:7];
  assign f3  = dec_instr[14:12];
  assign rs1 = dec_instr[19:15];
  assign rs2 = dec_instr[24:20];
  assign f7  = dec_instr[31:25];

  // slli needs funct7 zero and srli/srai zero or alt
  assign imm_shift_ok = (f3 == f3_sll)     ? (f7 == f7_base) :
                        (f3 == f3_srl_sra) ? (f7 == f7_base || f7 == f7_alt) : 1'b1;

  function automatic alu_op_t alu_sel(input logic [2:0] fn3, input logic alt);
    case (fn3)
      f3_add_sub: return alt ? alu_sub : alu_add;
      f3_sll:     return alu_sll;
      f3_slt:     return alu_slt;
      f3_sltu:    return alu_sltu;
      f3_xor:     return alu_xor;
      f3_srl_sra: return alt ? alu_sra : alu_srl;
      f3_or:      return alu_or;
      default:    return alu_and;
    endcase
  endfunction

  // decoder and immediate generator; anything unknown leaves ctrl zero
  always_comb
  begin
    ctrl = '0;
    imm  = '0;
    case (opc)
      opc_op:
      begin
        if (f7 == f7_base || (f7 == f7_alt && (f3 == f3_add_sub || f3 == f3_srl_sra)))
        begin
          ctrl.alu_op    = alu_sel(f3, f7 == f7_alt);
          ctrl.reg_write = 1'b1;
        end
      end
      opc_op_imm:
      begin
        if (imm_shift_ok && (dec_instr != nop_instr))  // canonical nop stays a bubble
        begin
          ctrl.alu_op    = alu_sel(f3, (f3 == f3_srl_sra) && (f7 == f7_alt));
          ctrl.use_imm   = 1'b1;
          ctrl.reg_write = 1'b1;
          imm = {{20{dec_instr[31]}}, dec_instr[31:20]};  // I type
        end
      end
      opc_lui:
      begin
        ctrl.alu_op    = alu_pass_b;
        ctrl.use_imm   = 1'b1;
        ctrl.zero_a    = 1'b1;  // rs1 field is immediate bits here
        ctrl.reg_write = 1'b1;
        imm = {dec_instr[31:12], 12'b0};  // U type
      end
      opc_load:
      begin
        if (f3 == f3_word)
        begin
          ctrl.alu_op    = alu_add;  // base + offset
          ctrl.use_imm   = 1'b1;
          ctrl.mem_read  = 1'b1;
          ctrl.reg_write = 1'b1;
          imm = {{20{dec_instr[31]}}, dec_instr[31:20]};
        end
      end
      opc_store:
      begin
        if (f3 == f3_word)
        begin
          ctrl.alu_op    = alu_add;
          ctrl.use_imm   = 1'b1;
          ctrl.mem_write = 1'b1;
          imm = {{20{dec_instr[31]}}, dec_instr[31:25], dec_instr[11:7]};  // S type
        end
      end
      default: ;
    endcase
  end

  register_file u_rf (
    .CLK (CLK),
    .rst (rst),
    .wr  (wr),
    .ra1 (rs1),
    .ra2 (rs2),
    .rd1 (rs1_data),
    .rd2 (rs2_data)
  );

  // decode to execute register
  always_ff @(posedge CLK)
  begin
    if (rst)
      id_ex.ctrl <= '0;
    else
      id_ex.ctrl <= ctrl;
    id_ex.rd       <= rd;
    id_ex.rs1      <= rs1;
    id_ex.rs2      <= rs2;
    id_ex.rs1_data <= rs1_data;
    id_ex.rs2_data <= rs2_data;
    id_ex.imm      <= imm;
  end

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
  import core_pkg::*;
(
  input  logic    CLK,
  input  logic    rst,
  input  id_ex_t  id_ex,
  input  wb_t     wb,      // second forwarding source
  output ex_mem_t ex_mem
);

  word_t fwd_a, fwd_b;   // rs1 / rs2 after forwarding
  word_t op_a, op_b;
  word_t alu_result;

  // newest producer wins so ex_mem goes before wb
  function automatic word_t fwd_sel(input reg_addr_t rs, input word_t rf_data,
                                    input ex_mem_t em, input wb_t w);
    if (rs == '0)
      return rf_data;  // x0 already reads zero
    else if (em.reg_write && (em.rd == rs))
      return em.alu_result;
    else if (w.reg_write && (w.rd == rs))
      return w.data;
    else
      return rf_data;
  endfunction

  assign fwd_a = fwd_sel(id_ex.rs1, id_ex.rs1_data, ex_mem, wb);
  assign fwd_b = fwd_sel(id_ex.rs2, id_ex.rs2_data, ex_mem, wb);

  assign op_a = id_ex.ctrl.zero_a  ? '0        : fwd_a;
  assign op_b = id_ex.ctrl.use_imm ? id_ex.imm : fwd_b;

  always_comb
  begin
    case (id_ex.ctrl.alu_op)
      alu_add:    alu_result = op_a + op_b;
      alu_sub:    alu_result = op_a - op_b;
      alu_and:    alu_result = op_a & op_b;
      alu_or:     alu_result = op_a | op_b;
      alu_xor:    alu_result = op_a ^ op_b;
      alu_sll:    alu_result = op_a << op_b[4:0];   // shamt is low 5 bits
      alu_srl:    alu_result = op_a >> op_b[4:0];
      alu_sra:    alu_result = word_t'($signed(op_a) >>> op_b[4:0]);
      alu_slt:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      alu_sltu:   alu_result = {31'b0, op_a < op_b};
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // execute to memory register
  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      ex_mem.mem_read  <= 1'b0;
      ex_mem.mem_write <= 1'b0;
      ex_mem.reg_write <= 1'b0;
    end
    else
    begin
      ex_mem.mem_read  <= id_ex.ctrl.mem_read;
      ex_mem.mem_write <= id_ex.ctrl.mem_write;
      ex_mem.reg_write <= id_ex.ctrl.reg_write;
    end
    ex_mem.rd         <= id_ex.rd;
    ex_mem.alu_result <= alu_result;
    ex_mem.store_data <= fwd_b;  // forwarded rs2 for sw
  end

endmodule

// File: verilog/register_file.sv
`timescale 1ns/1ps

module register_file
  import core_pkg::*;
(
  input  logic      CLK,
  input  logic      rst,
  input  wb_t       wr,   // write port from writeback
  input  reg_addr_t ra1,
  input  reg_addr_t ra2,
  output word_t     rd1,
  output word_t     rd2
);

  word_t regs [1:31];  // x0 is not stored

  // x0 reads zero and a same-cycle write is seen at once
  function automatic word_t read_port(input reg_addr_t ra);
    if (ra == '0)
      return '0;
    else if (wr.reg_write && (wr.rd == ra))
      return wr.data;  // write-through
    else
      return regs[ra];
  endfunction

  always_comb
  begin
    rd1 = read_port(ra1);
    rd2 = read_port(ra2);
  end

  always_ff @(posedge CLK)
  begin
    if (rst)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (wr.reg_write && (wr.rd != '0))
      regs[wr.rd] <= wr.data;  // writes to x0 dropped
  end

endmodule

// File: verilog/result_stage.sv
`timescale 1ns/1ps

module result_stage
  import core_pkg::*;
(
  input  logic    CLK,
  input  logic    rst,
  input  ex_mem_t ex_mem,
  input  word_t   d_mem_rdata,  // same-cycle read data
  output logic    d_mem_en,
  output logic    d_mem_we,
  output word_t   d_mem_addr,
  output word_t   d_mem_wdata,
  output wb_t     wb
);

  word_t result;  // value headed for rd

  // data memory driven straight from the ex_mem register
  assign d_mem_en    = !rst && (ex_mem.mem_read || ex_mem.mem_write);
  assign d_mem_we    = !rst && ex_mem.mem_write;
  assign d_mem_addr  = ex_mem.alu_result;
  assign d_mem_wdata = ex_mem.store_data;

  assign result = ex_mem.mem_read ? d_mem_rdata : ex_mem.alu_result;

  // memory to writeback register that doubles as the rf write port
  always_ff @(posedge CLK)
  begin
    if (rst)
      wb.reg_write <= 1'b0;
    else
      wb.reg_write <= ex_mem.reg_write;
    wb.rd   <= ex_mem.rd;
    wb.data <= result;  // loaded word or alu result
  end

endmodule

// File: verilog/riscv_core.sv
`timescale 1ns/1ps

module riscv_core
  import core_pkg::*;
(
  input  logic  CLK,
  input  logic  rst,
  // instruction memory
  output word_t i_mem_addr,   // pc
  output logic  i_mem_en,
  input  word_t i_mem_rdata,  // combinational read
  // data memory
  output logic  d_mem_en,
  output logic  d_mem_we,
  output word_t d_mem_addr,
  output word_t d_mem_wdata,
  input  word_t d_mem_rdata
);

  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  wb_t     wb;  // rf write and forwarding source

  decode_stage u_decode (
    .CLK      (CLK),
    .rst      (rst),
    .instr    (i_mem_rdata),
    .wr       (wb),
    .pc       (i_mem_addr),
    .fetch_en (i_mem_en),
    .id_ex    (id_ex)
  );

  execute_stage u_execute (
    .CLK    (CLK),
    .rst    (rst),
    .id_ex  (id_ex),
    .wb     (wb),
    .ex_mem (ex_mem)
  );

  result_stage u_result (
    .CLK         (CLK),
    .rst         (rst),
    .ex_mem      (ex_mem),
    .d_mem_rdata (d_mem_rdata),
    .d_mem_en    (d_mem_en),
    .d_mem_we    (d_mem_we),
    .d_mem_addr  (d_mem_addr),
    .d_mem_wdata (d_mem_wdata),
    .wb          (wb)
  );

endmodule
